/* list.f */
counter_pkg.sv
request_issue.sv
counter_table_ram.sv
result_stage.sv
counter_table_top.sv
tb_counter_table.sv

/* Bender.yml */
package:
  name: counter_table

dependencies: {}

sources:
  # design
  - files:
      - counter_pkg.sv
      - request_issue.sv
      - counter_table_ram.sv
      - result_stage.sv
      - counter_table_top.sv

  # testbench
  - target: test
    files:
      - tb_counter_table.sv

/* tb_counter_table.sv */
`timescale 1ns/1ps

module tb_counter_table;

    import counter_pkg::*;

    localparam int clock_half    = 50;      // 100 ns period
    localparam int reset_cycles  = 8;
    localparam int init_limit    = 66;      // cycles from reset release to init_done
    localparam int random_cycles = 1000;
    localparam int max_cycles    = 3000;    // about twice the expected run length

    logic       clock;
    logic       rst_n;
    logic       upd_valid;
    key_t       upd_key;
    count_t     upd_incr;
    logic       query_valid;
    entry_idx_t query_entry;
    logic       init_done;
    logic       resp_valid;
    entry_t     resp_data;

    count_t     model [entry_count*lane_count];  // one slot per counter key
    int         error_count   = 0;
    int         resp_checked  = 0;
    int         cycle_count   = 0;
    int         seed          = 32'hdac8;

    logic       init_seen     = 1'b0;   // table clear observed
    logic       qry_sent      = 1'b0;   // accepted query driven this cycle
    entry_t     qry_exp       = '0;
    logic       resp_due      = 1'b0;   // response expected this cycle
    entry_t     resp_due_val  = '0;

    counter_table_top i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .upd_valid   (upd_valid),
        .upd_key     (upd_key),
        .upd_incr    (upd_incr),
        .query_valid (query_valid),
        .query_entry (query_entry),
        .init_done   (init_done),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #clock_half clock = ~clock;
        end
    end

    // ########################################################################
    // reference model

    function automatic key_t make_key(input int e, input int l);
        return key_t'(e * lane_count + l);
    endfunction

    function automatic entry_t expected_entry(input int e);
        entry_t result;
        for (int l = 0; l < lane_count; l++) begin
            result[l*lane_width +: lane_width] = model[e*lane_count + l];
        end
        return result;
    endfunction

    // one clock of stimulus, model follows only accepted strobes
    task automatic drive_cycle(
        input logic   uv,
        input key_t   k,
        input count_t inc,
        input logic   qv,
        input int     qe
    );
        logic accept;
        @(posedge clock);
        #1;
        accept      = init_seen;
        upd_valid   = uv;
        upd_key     = k;
        upd_incr    = inc;
        query_valid = qv;
        query_entry = entry_idx_t'(qe);
        qry_sent    = qv && accept;
        if (qv && accept) begin
            qry_exp = expected_entry(qe);  // before this cycle's update
        end
        if (uv && accept) begin
            model[k] = model[k] + inc;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b0, 0);
        end
    endtask

    // ########################################################################
    // response checking

    always @(posedge clock) begin
        resp_due     <= qry_sent;
        resp_due_val <= qry_exp;
    end

    always @(negedge clock) begin
        if (rst_n) begin
            if (init_seen && init_done !== 1'b1) begin
                error_count++;
                $display("** Error at %0t: init_done expected 1 got %b", $time, init_done);
            end
            if (resp_due && resp_valid !== 1'b1) begin
                error_count++;
                $display("** Error at %0t: resp_valid expected 1 got %b", $time, resp_valid);
            end else if (!resp_due && resp_valid !== 1'b0) begin
                error_count++;
                $display("** Error at %0t: resp_valid expected 0 got %b", $time, resp_valid);
            end else if (resp_due) begin
                resp_checked++;
                if (resp_data !== resp_due_val) begin
                    error_count++;
                    $display("** Error at %0t: resp_data expected %h got %h",
                             $time, resp_due_val, resp_data);
                end
            end
        end
    end

    // ########################################################################
    // timeout

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("errors: %0d, responses checked: %0d", error_count + 1, resp_checked);
        $display("TEST FAILED");
        $finish;
    end

    // ########################################################################
    // stimulus

    initial begin
        int          clear_cycles;
        logic [31:0] r;
        key_t        k;
        int          qe;

        rst_n       = 1'b0;
        upd_valid   = 1'b0;
        upd_key     = '0;
        upd_incr    = '0;
        query_valid = 1'b0;
        query_entry = '0;
        for (int i = 0; i < entry_count*lane_count; i++) begin
            model[i] = '0;
        end

        repeat (reset_cycles) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // strobes during the clear are dropped
        clear_cycles = 1;
        do begin
            @(posedge clock);
            #1;
            if (init_done) begin
                init_seen   = 1'b1;
                upd_valid   = 1'b0;
                query_valid = 1'b0;
            end else begin
                clear_cycles++;
                r           = $random(seed);
                upd_valid   = 1'b1;
                upd_key     = r[7:0];
                upd_incr    = r[15:8];
                query_valid = 1'b1;
                query_entry = r[21:16];
            end
        end while (!init_done && clear_cycles <= init_limit);

        if (!init_done) begin
            error_count++;
            $display("init_done did not rise within %0d cycles of reset release",
                     init_limit);
        end

        // whole table reads back zero
        for (int e = 0; e < entry_count; e++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, e);
        end
        idle_cycles(2);

        // single updates per lane, then wrap on lane 1
        for (int l = 0; l < lane_count; l++) begin
            drive_cycle(1'b1, make_key(5, l), count_t'(l*16 + 3), 1'b0, 0);
            drive_cycle(1'b0, '0, '0, 1'b1, 5);
        end
        for (int n = 0; n < 20; n++) begin
            drive_cycle(1'b1, make_key(5, 1), 8'h1d, 1'b0, 0);
        end
        drive_cycle(1'b0, '0, '0, 1'b1, 5);
        drive_cycle(1'b0, '0, '0, 1'b1, 4);  // neighbour untouched
        idle_cycles(2);

        // back-to-back on one key, then across lanes of one entry
        for (int n = 0; n < 8; n++) begin
            drive_cycle(1'b1, make_key(9, 3), count_t'(n + 1), 1'b0, 0);
        end
        for (int n = 0; n < 10; n++) begin
            drive_cycle(1'b1, make_key(9, n % lane_count), count_t'(7*n + 2), 1'b0, 0);
        end
        drive_cycle(1'b0, '0, '0, 1'b1, 9);
        idle_cycles(2);

        // query timing against updates
        drive_cycle(1'b1, make_key(12, 0), 8'h11, 1'b0, 0);
        drive_cycle(1'b0, '0, '0, 1'b1, 12);             // sees previous update
        drive_cycle(1'b1, make_key(12, 2), 8'h05, 1'b1, 12);  // same cycle, not seen
        drive_cycle(1'b0, '0, '0, 1'b1, 12);
        drive_cycle(1'b1, make_key(12, 3), 8'hf0, 1'b1, 13);
        drive_cycle(1'b1, make_key(12, 3), 8'h20, 1'b1, 12);
        drive_cycle(1'b0, '0, '0, 1'b1, 12);
        idle_cycles(3);

        // random stream
        for (int n = 0; n < random_cycles; n++) begin
            r = $random(seed);
            k = r[9:2];
            if (r[10]) begin
                k[7:4] = '0;  // crowd a few entries
            end
            qe = r[17] ? int'(r[12:11]) : int'(r[16:11]);
            drive_cycle(r[0], k, count_t'(r[25:18]), r[1], qe);
        end
        idle_cycles(3);

        // final sweep of the whole table
        for (int e = 0; e < entry_count; e++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, e);
        end
        idle_cycles(3);

        if (resp_checked == 0) begin
            error_count++;
            $display("no query response was ever checked");
        end

        $display("errors: %0d, responses checked: %0d", error_count, resp_checked);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* counter_table_top.sv */
`timescale 1ns/1ps

module counter_table_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    upd_valid,
    input  counter_pkg::key_t       upd_key,
    input  counter_pkg::count_t     upd_incr,
    input  logic                    query_valid,
    input  counter_pkg::entry_idx_t query_entry,
    output logic                    init_done,
    output logic                    resp_valid,
    output counter_pkg::entry_t     resp_data
);

    import counter_pkg::*;

    logic       rd_en_a;
    entry_idx_t rd_addr_a;
    logic       rd_en_b;
    entry_idx_t rd_addr_b;
    entry_t     rd_data_a;
    entry_t     rd_data_b;
    issued_op_t issued_op;
    logic       query_issued;
    table_wr_t  wr;

    request_issue i_issue (
        .clock        (clock),
        .rst_n        (rst_n),
        .upd_valid    (upd_valid),
        .upd_key      (upd_key),
        .upd_incr     (upd_incr),
        .query_valid  (query_valid),
        .query_entry  (query_entry),
        .init_done    (init_done),
        .rd_en_a      (rd_en_a),
        .rd_addr_a    (rd_addr_a),
        .rd_en_b      (rd_en_b),
        .rd_addr_b    (rd_addr_b),
        .issued_op    (issued_op),
        .query_issued (query_issued)
    );

    counter_table_ram #(
        .entries (entry_count),
        .lanes   (lane_count)
    ) i_ram (
        .clock     (clock),
        .rd_en_a   (rd_en_a),
        .rd_addr_a (rd_addr_a),
        .rd_en_b   (rd_en_b),
        .rd_addr_b (rd_addr_b),
        .wr        (wr),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    result_stage i_result (
        .clock        (clock),
        .rst_n        (rst_n),
        .issued_op    (issued_op),
        .query_issued (query_issued),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .wr           (wr),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data)
    );

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    input  logic                    clock,
    input  logic                    rst_n,
    input  counter_pkg::issued_op_t issued_op,
    input  logic                    query_issued,
    input  counter_pkg::entry_t     rd_data_a,
    input  counter_pkg::entry_t     rd_data_b,
    output counter_pkg::table_wr_t  wr,
    output logic                    resp_valid,
    output counter_pkg::entry_t     resp_data
);

    import counter_pkg::*;

    count_t     cur_count;
    count_t     new_count;
    lane_mask_t lane_sel;

    // ########################################################################
    // counter update

    always_comb begin
        cur_count = rd_data_a[issued_op.lane*lane_width +: lane_width];
        new_count = cur_count + issued_op.incr;  // wraps mod 256
    end

    always_comb begin
        lane_sel = '0;
        lane_sel[issued_op.lane] = 1'b1;
    end

    // write back only the addressed lane, or every lane on clear
    always_comb begin
        wr.addr = issued_op.entry;
        wr.mask = '0;
        wr.data = {lane_count{new_count}};
        if (issued_op.clear) begin
            wr.mask = '1;
            wr.data = '0;
        end else if (issued_op.valid) begin
            wr.mask = lane_sel;
        end
    end

    // ########################################################################
    // query response

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= query_issued;
        end
    end

    // port b output register already holds the entry read with the query
    assign resp_data = rd_data_b;

endmodule

/* counter_table_ram.sv */
`timescale 1ns/1ps

module counter_table_ram #(
    parameter int entries = counter_pkg::entry_count,
    parameter int lanes   = counter_pkg::lane_count
) (
    input  logic                    clock,
    input  logic                    rd_en_a,
    input  counter_pkg::entry_idx_t rd_addr_a,
    input  logic                    rd_en_b,
    input  counter_pkg::entry_idx_t rd_addr_b,
    input  counter_pkg::table_wr_t  wr,
    output counter_pkg::entry_t     rd_data_a,
    output counter_pkg::entry_t     rd_data_b
);

    import counter_pkg::*;

    localparam int lane_w = $bits(entry_t) / lanes;

    entry_t mem [entries];
    entry_t fwd_a;
    entry_t fwd_b;

    // stored entry with same-cycle write lanes laid over it
    function automatic entry_t merge_wr(
        input entry_t     stored,
        input entry_idx_t addr,
        input table_wr_t  w
    );
        entry_t result;
        result = stored;
        for (int i = 0; i < lanes; i++) begin
            if (w.mask[i] && (w.addr == addr)) begin
                result[i*lane_w +: lane_w] = w.data[i*lane_w +: lane_w];
            end
        end
        return result;
    endfunction

    // ########################################################################
    // write port, lane masked

    always_ff @(posedge clock) begin
        for (int i = 0; i < lanes; i++) begin
            if (wr.mask[i]) begin
                mem[wr.addr][i*lane_w +: lane_w] <= wr.data[i*lane_w +: lane_w];
            end
        end
    end

    // ########################################################################
    // read ports with write forwarding

    always_comb begin
        fwd_a = merge_wr(mem[rd_addr_a], rd_addr_a, wr);
        fwd_b = merge_wr(mem[rd_addr_b], rd_addr_b, wr);
    end

    always_ff @(posedge clock) begin
        if (rd_en_a) begin
            rd_data_a <= fwd_a;
        end
        if (rd_en_b) begin
            rd_data_b <= fwd_b;  // holds when idle
        end
    end

endmodule

/* request_issue.sv */
`timescale 1ns/1ps

module request_issue (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    upd_valid,
    input  counter_pkg::key_t       upd_key,
    input  counter_pkg::count_t     upd_incr,
    input  logic                    query_valid,
    input  counter_pkg::entry_idx_t query_entry,
    output logic                    init_done,
    output logic                    rd_en_a,
    output counter_pkg::entry_idx_t rd_addr_a,
    output logic                    rd_en_b,
    output counter_pkg::entry_idx_t rd_addr_b,
    output counter_pkg::issued_op_t issued_op,
    output logic                    query_issued
);

    import counter_pkg::*;

    issue_state_t state;
    entry_idx_t   clr_idx;
    logic         clearing;
    logic         upd_go;
    logic         qry_go;
    entry_idx_t   upd_entry;
    lane_idx_t    upd_lane;

    // ########################################################################
    // init clear sequencer

    assign clearing  = (state == st_clear);
    assign init_done = (state == st_run);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= st_clear;
            clr_idx <= '0;
        end else begin
            case (state)
                st_clear: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == entry_idx_t'(entry_count - 1)) begin
                        state <= st_run;  // last clear issued this cycle
                    end
                end
                st_run: begin
                    state <= st_run;
                end
                default: begin
                    state <= st_clear;
                end
            endcase
        end
    end

    // ########################################################################
    // read port issue

    // strobes are dropped until the table is cleared
    assign upd_go    = upd_valid && !clearing;
    assign qry_go    = query_valid && !clearing;

    assign upd_entry = upd_key[lane_bits +: entry_bits];
    assign upd_lane  = upd_key[lane_bits-1:0];

    assign rd_en_a   = upd_go;             // update read
    assign rd_addr_a = upd_entry;
    assign rd_en_b   = qry_go;             // query read
    assign rd_addr_b = query_entry;

    assign query_issued = qry_go;          // answered once port b data is out

    // ########################################################################
    // issued operation, meets read data one cycle later

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            issued_op.valid <= 1'b0;
            issued_op.clear <= 1'b0;
        end else begin
            issued_op.valid <= upd_go;
            issued_op.clear <= clearing;
        end
    end

    always_ff @(posedge clock) begin
        issued_op.entry <= clearing ? clr_idx : upd_entry;
        issued_op.lane  <= upd_lane;
        issued_op.incr  <= upd_incr;
    end

endmodule

/* counter_pkg.sv */
package counter_pkg;

    // ########################################################################
    // table geometry

    localparam int entry_count = 64;
    localparam int lane_count  = 4;
    localparam int lane_width  = 8;

    localparam int entry_bits  = $clog2(entry_count);
    localparam int lane_bits   = $clog2(lane_count);
    localparam int key_bits    = entry_bits + lane_bits;

    // ########################################################################
    // basic types

    typedef logic [entry_bits-1:0]            entry_idx_t;
    typedef logic [lane_bits-1:0]             lane_idx_t;
    typedef logic [key_bits-1:0]              key_t;    // entry in upper bits, lane in lower
    typedef logic [lane_width-1:0]            count_t;
    typedef logic [lane_count-1:0]            lane_mask_t;
    typedef logic [lane_count*lane_width-1:0] entry_t;  // lane 0 in low byte

    typedef enum logic {
        st_clear,
        st_run
    } issue_state_t;

    // ########################################################################
    // pipeline structs

    // operation issued one cycle earlier, lines up with ram read data
    typedef struct packed {
        logic       valid;  // counter update
        logic       clear;  // init clear of one entry
        entry_idx_t entry;
        lane_idx_t  lane;
        count_t     incr;
    } issued_op_t;

    typedef struct packed {
        entry_idx_t addr;
        lane_mask_t mask;   // zero mask means no write
        entry_t     data;
    } table_wr_t;

endpackage
